// File: compile.f
+incdir+verilog
verilog/video_pkg.sv
verilog/maze_pkg.sv
verilog/scan_decode.sv
verilog/maze_map.sv
verilog/player_ctrl.sv
verilog/pixel_compose.sv
verilog/maze_display_top.sv
tb/maze_display_assert.sv
tb/maze_display_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the maze display testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=maze_display_sim
LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps \
  -f compile.f --top-module maze_display_tb \
  --Mdir "$BUILD_DIR" -o "$SIM_BIN"
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "^No errors$" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// File: tb/maze_display_tb.sv
// Directed tests of the maze display; checked pixels are compared in full.
// Covers frame 0 and the upper part of frame 1, moves run during vertical blanking.
`timescale 1ns/1ps
`include "maze_cfg.svh"

module maze_display_tb;

  localparam int H_TOTAL  = `MAZE_H_TOTAL;
  localparam int V_TOTAL  = `MAZE_V_TOTAL;
  localparam int HS_START = `MAZE_H_ACTIVE + `MAZE_H_FRONT;
  localparam int VS_START = `MAZE_V_ACTIVE + `MAZE_V_FRONT;
  localparam int CLK_NS   = 40;
  // Two frames plus reset and a few lines of margin
  localparam int TIMEOUT_NS = (2 * H_TOTAL * V_TOTAL + 16 + 8 * H_TOTAL) * CLK_NS;

  localparam video_pkg::vga_pixel_t BLANK_PIXEL =
    '{sync: '{hsync: 1'b1, vsync: 1'b1, active: 1'b0}, color: 8'h00};

  logic                  d;
  logic                  rst_n;
  maze_pkg::move_t       move;
  logic [7:0]            wall_color;
  video_pkg::vga_pixel_t vga;
  maze_pkg::tile_t       player;
  logic                  at_goal;

  logic [31:0]     lcg_state;
  int              since_rst;
  int              exp_x;
  int              exp_y;
  maze_pkg::tile_t exp_player;
  logic            exp_goal;
  logic            failed;
  logic            done;

  maze_display_top dut0 (
    .d          (d),
    .rst_n      (rst_n),
    .move       (move),
    .wall_color (wall_color),
    .vga        (vga),
    .player     (player),
    .at_goal    (at_goal)
  );

  initial begin
    d = 1'b0;
    forever #(CLK_NS / 2) d = ~d;
  end

  initial begin
    #(TIMEOUT_NS);
    failed = 1'b1;
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

  // Catches a run stopped by a failing assertion
  final begin
    if (!done && !failed) begin
      $display("Errors found");
    end
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic tile_is_wall(int col, int row);
    if (col < 0 || row < 0 || col >= `MAZE_MAP_COLS || row >= `MAZE_MAP_ROWS) begin
      return 1'b1;
    end
    return maze_pkg::MAZE_WALLS[4'(row)][5'(col)];
  endfunction

  function automatic video_pkg::vga_pixel_t expected_pixel(int x, int y);
    video_pkg::vga_pixel_t p;
    int col;
    int row;
    col = x / `MAZE_TILE_W;
    row = y / `MAZE_TILE_H;
    p.sync.hsync  = !(x >= HS_START && x < HS_START + `MAZE_H_SYNC);
    p.sync.vsync  = !(y >= VS_START && y < VS_START + `MAZE_V_SYNC);
    p.sync.active = (x < `MAZE_H_ACTIVE) && (y < `MAZE_V_ACTIVE);
    if (!p.sync.active) begin
      p.color = 8'h00;
    end else if (col == int'(exp_player.col) && row == int'(exp_player.row)) begin
      p.color = `MAZE_PLAYER_COLOR;
    end else if (tile_is_wall(col, row)) begin
      p.color = wall_color;
    end else begin
      p.color = `MAZE_BG_COLOR;
    end
    return p;
  endfunction

  // --------------------------------------------------------------------------
  // Clocking and compare tasks
  // --------------------------------------------------------------------------

  task automatic stop_with_failure();
    failed = 1'b1;
    $display("Errors found");
    $fatal(1, "stopping at the first error");
  endtask

  // Output pixel 0,0 appears on the second edge after reset release
  task automatic step();
    @(posedge d);
    #2;
    if (!rst_n) begin
      since_rst = 0;
      exp_x     = 0;
      exp_y     = 0;
    end else if (since_rst < 2) begin
      since_rst++;
    end else begin
      exp_x++;
      if (exp_x == H_TOTAL) begin
        exp_x = 0;
        exp_y = (exp_y + 1) % V_TOTAL;
      end
    end
  endtask

  task automatic check_pixel(string name, video_pkg::vga_pixel_t got,
                             video_pkg::vga_pixel_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s at x=%0d y=%0d got %h expected %h",
               $time, name, exp_x, exp_y, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_tile(string name, maze_pkg::tile_t got, maze_pkg::tile_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got col %0d row %0d expected col %0d row %0d",
               $time, name, got.col, got.row, exp.col, exp.row);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  // Pulse order is up, down, left, right; the model applies the move rules
  task automatic apply_move(logic [3:0] pulses);
    int col;
    int row;
    col = int'(exp_player.col);
    row = int'(exp_player.row);
    case (pulses)
      4'b1000: row--;
      4'b0100: row++;
      4'b0010: col--;
      4'b0001: col++;
      default: ;
    endcase
    if (!exp_goal && !tile_is_wall(col, row)) begin
      exp_player.col = 5'(col);
      exp_player.row = 4'(row);
      exp_goal = (col == `MAZE_GOAL_COL) && (row == `MAZE_GOAL_ROW);
    end
    move = pulses;
    step();
    move = '0;
    check_tile("player", player, exp_player);
    check_bit("at_goal", at_goal, exp_goal);
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------

  task automatic verify_reset();
    repeat (16) begin
      step();
      check_pixel("vga", vga, BLANK_PIXEL);
    end
    rst_n = 1'b1;
    step();
    check_pixel("vga", vga, BLANK_PIXEL);
    check_tile("player", player, exp_player);
    check_bit("at_goal", at_goal, 1'b0);
  endtask

  task automatic map_colors_frame0();
    for (int i = 0; i < H_TOTAL * `MAZE_V_ACTIVE; i++) begin
      step();
      check_pixel("vga", vga, expected_pixel(exp_x, exp_y));
    end
  endtask

  task automatic blocked_moves();
    apply_move(4'b1000);
    apply_move(4'b0010);
    apply_move(4'b0100);
    apply_move(4'b1001);
    apply_move(4'b1111);
  endtask

  task automatic walk_to_goal();
    logic [31:0] r;
    repeat (`MAZE_GOAL_COL - `MAZE_START_COL) apply_move(4'b0001);
    repeat (`MAZE_GOAL_ROW - `MAZE_START_ROW) apply_move(4'b0100);
    check_bit("at_goal", at_goal, 1'b1);
    // The tile above the goal is open, so this pulse must be ignored
    apply_move(4'b1000);
    // Random pulses once the goal is reached
    repeat (8) begin
      r = lcg_next();
      apply_move(4'b0001 << r[17:16]);
    end
  endtask

  task automatic sync_through_vblank();
    int vs_low;
    vs_low = 0;
    while (!(exp_x == H_TOTAL - 1 && exp_y == V_TOTAL - 1)) begin
      step();
      check_pixel("vga", vga, expected_pixel(exp_x, exp_y));
      if (!vga.sync.vsync) begin
        vs_low++;
      end
    end
    if (vs_low != `MAZE_V_SYNC * H_TOTAL) begin
      $display("FAILED at %0t: vga.sync.vsync low cycles got %0d expected %0d",
               $time, vs_low, `MAZE_V_SYNC * H_TOTAL);
      stop_with_failure();
    end
  endtask

  task automatic goal_marker_frame1();
    int marker_px;
    marker_px = 0;
    for (int i = 0; i < H_TOTAL * (`MAZE_GOAL_ROW + 1) * `MAZE_TILE_H; i++) begin
      step();
      check_pixel("vga", vga, expected_pixel(exp_x, exp_y));
      if (vga.color == `MAZE_PLAYER_COLOR) begin
        marker_px++;
      end
    end
    if (marker_px != `MAZE_TILE_W * `MAZE_TILE_H) begin
      $display("FAILED at %0t: marker pixel count got %0d expected %0d",
               $time, marker_px, `MAZE_TILE_W * `MAZE_TILE_H);
      stop_with_failure();
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    move       = '0;
    lcg_state  = 32'hdfaa;
    wall_color = 8'h00;
    since_rst  = 0;
    exp_x      = 0;
    exp_y      = 0;
    exp_player = '{col: 5'(`MAZE_START_COL), row: 4'(`MAZE_START_ROW)};
    exp_goal   = 1'b0;
    failed     = 1'b0;
    done       = 1'b0;
    // Wall colour must differ from black, background and marker
    while (wall_color == 8'h00 || wall_color == `MAZE_BG_COLOR ||
           wall_color == `MAZE_PLAYER_COLOR) begin
      wall_color = 8'(lcg_next() >> 16);
    end
    verify_reset();
    map_colors_frame0();
    blocked_moves();
    walk_to_goal();
    sync_through_vblank();
    goal_marker_frame1();
    if (failed) begin
      $display("Errors found");
      $fatal(1, "checks failed");
    end else begin
      done = 1'b1;
      $display("No errors");
      $finish;
    end
  end

endmodule

// File: tb/maze_display_assert.sv
// Concurrent checks on the map stage and the top-level outputs.
// All checks are disabled while rst_n is low.
`timescale 1ns/1ps
`include "maze_cfg.svh"

module maze_display_assert (
  input logic                  d,
  input logic                  rst_n,
  input maze_pkg::tile_t       tile,
  input logic [7:0]            wall_color,
  input logic [7:0]            map_color,
  input video_pkg::vga_pixel_t vga,
  input maze_pkg::tile_t       player,
  input logic                  at_goal
);

  logic tile_wall;
  logic player_wall;

  // Off-grid tiles count as wall
  function automatic logic wall_at(maze_pkg::tile_t t);
    if (t.col >= 5'(`MAZE_MAP_COLS) || t.row >= 4'(`MAZE_MAP_ROWS)) begin
      return 1'b1;
    end
    return maze_pkg::MAZE_WALLS[t.row][t.col];
  endfunction

  always_comb begin
    tile_wall   = wall_at(tile);
    player_wall = wall_at(player);
  end

  // Map colour is one cycle behind the tile and the wall colour
  a_map_color: assert property (@(posedge d) disable iff (!rst_n)
    map_color == ($past(tile_wall) ? $past(wall_color) : `MAZE_BG_COLOR))
    else $error("map_color does not follow the wall map");

  a_blank: assert property (@(posedge d) disable iff (!rst_n)
    !vga.sync.active |-> vga.color == 8'h00)
    else $error("colour is not blanked outside the active area");

  a_player_open: assert property (@(posedge d) disable iff (!rst_n) !player_wall)
    else $error("player sits on a wall tile");

  a_goal_sticky: assert property (@(posedge d) disable iff (!rst_n) at_goal |=> at_goal)
    else $error("at_goal fell without a reset");

endmodule

bind maze_display_top maze_display_assert u_check (
  .d          (d),
  .rst_n      (rst_n),
  .tile       (tile),
  .wall_color (wall_color),
  .map_color  (map_color),
  .vga        (vga),
  .player     (player),
  .at_goal    (at_goal)
);

// File: verilog/maze_display_top.sv
// Raster to VGA output is two cycles; moves are independent of the raster.
`timescale 1ns/1ps

module maze_display_top (
  input  logic                   d,
  input  logic                   rst_n,
  input  maze_pkg::move_t        move,
  input  logic [7:0]             wall_color,
  output video_pkg::vga_pixel_t  vga,
  output maze_pkg::tile_t        player,
  output logic                   at_goal
);

  // Decode stage outputs, all for the same pixel
  maze_pkg::tile_t        tile;
  video_pkg::sync_t       sync;

  // Map stage outputs
  logic [7:0]             map_color;
  video_pkg::sync_t       map_sync;
  maze_pkg::tile_t        tile_d;

  scan_decode u_scan (
    .d     (d),
    .rst_n (rst_n),
    .pos   (),
    .tile  (tile),
    .sync  (sync)
  );

  maze_map u_map (
    .d          (d),
    .rst_n      (rst_n),
    .tile       (tile),
    .sync       (sync),
    .wall_color (wall_color),
    .map_color  (map_color),
    .map_sync   (map_sync)
  );

  // Tile follows the map stage so it lines up with map_color
  always_ff @(posedge d) begin
    tile_d <= tile;
  end

  player_ctrl u_player (
    .d       (d),
    .rst_n   (rst_n),
    .move    (move),
    .player  (player),
    .at_goal (at_goal)
  );

  pixel_compose u_compose (
    .d         (d),
    .rst_n     (rst_n),
    .map_color (map_color),
    .map_sync  (map_sync),
    .tile      (tile_d),
    .player    (player),
    .vga       (vga)
  );

endmodule

// File: verilog/pixel_compose.sv
// Last stage of the video path; the marker fills the whole player tile.
`timescale 1ns/1ps
`include "maze_cfg.svh"

module pixel_compose (
  input  logic                   d,
  input  logic                   rst_n,
  input  logic [7:0]             map_color,
  input  video_pkg::sync_t       map_sync,
  input  maze_pkg::tile_t        tile,
  input  maze_pkg::tile_t        player,
  output video_pkg::vga_pixel_t  vga
);

  logic       on_player;
  logic [7:0] color_next;

  // -------------------------------------------------------------------------
  // Overlay and blanking
  // -------------------------------------------------------------------------

  always_comb begin
    on_player = (tile == player);
    if (!map_sync.active) begin
      color_next = 8'h00;
    end else if (on_player) begin
      color_next = `MAZE_PLAYER_COLOR;
    end else begin
      color_next = map_color;
    end
  end

  // -------------------------------------------------------------------------
  // Output register
  // -------------------------------------------------------------------------

  // Syncs released and colour black while in reset
  always_ff @(posedge d) begin
    if (!rst_n) begin
      vga <= video_pkg::PIXEL_IDLE;
    end else begin
      vga.sync  <= map_sync;
      vga.color <= color_next;
    end
  end

endmodule

// File: verilog/player_ctrl.sv
// Move pulses are one-hot and taken in the cycle they are seen.
// Once the goal is reached the player is frozen until reset.
`timescale 1ns/1ps
`include "maze_cfg.svh"

module player_ctrl (
  input  logic             d,
  input  logic             rst_n,
  input  maze_pkg::move_t  move,
  output maze_pkg::tile_t  player,
  output logic             at_goal
);

  maze_pkg::move_op_e      op;
  maze_pkg::player_state_e state;
  maze_pkg::tile_t         target;
  logic                    target_open;

  // -------------------------------------------------------------------------
  // Move decode
  // -------------------------------------------------------------------------

  // More than one pulse at a time is treated as no move
  always_comb begin
    case ({move.up, move.down, move.left, move.right})
      4'b1000: op = maze_pkg::MOVE_UP;
      4'b0100: op = maze_pkg::MOVE_DOWN;
      4'b0010: op = maze_pkg::MOVE_LEFT;
      4'b0001: op = maze_pkg::MOVE_RIGHT;
      default: op = maze_pkg::MOVE_NONE;
    endcase
  end

  // Stepping off row 0 or column 0 wraps to a value outside the grid
  always_comb begin
    target = player;
    case (op)
      maze_pkg::MOVE_UP:    target.row = player.row - 4'd1;
      maze_pkg::MOVE_DOWN:  target.row = player.row + 4'd1;
      maze_pkg::MOVE_LEFT:  target.col = player.col - 5'd1;
      maze_pkg::MOVE_RIGHT: target.col = player.col + 5'd1;
      default:              target = player;
    endcase
    target_open = (op != maze_pkg::MOVE_NONE) && !maze_pkg::is_wall(target);
  end

  // -------------------------------------------------------------------------
  // Player FSM
  // -------------------------------------------------------------------------

  always_ff @(posedge d) begin
    if (!rst_n) begin
      state  <= maze_pkg::PLAY_ROAM;
      player <= maze_pkg::START_TILE;
    end else begin
      case (state)
        maze_pkg::PLAY_ROAM: begin
          if (target_open) begin
            player <= target;
            if (target == maze_pkg::GOAL_TILE) begin
              state <= maze_pkg::PLAY_GOAL;
            end
          end
        end
        default: begin
          state <= maze_pkg::PLAY_GOAL;
        end
      endcase
    end
  end

  assign at_goal = (state == maze_pkg::PLAY_GOAL);

endmodule

// File: verilog/maze_map.sv
// One cycle from tile to colour; wall_color is sampled with the tile.
// Tiles in the blanking region still get a colour and are blanked later.
`timescale 1ns/1ps
`include "maze_cfg.svh"

module maze_map (
  input  logic              d,
  input  logic              rst_n,
  input  maze_pkg::tile_t   tile,
  input  video_pkg::sync_t  sync,
  input  logic [7:0]        wall_color,
  output logic [7:0]        map_color,
  output video_pkg::sync_t  map_sync
);

  logic       wall_hit;
  logic [7:0] color_next;

  always_comb begin
    wall_hit   = maze_pkg::is_wall(tile);
    color_next = wall_hit ? wall_color : `MAZE_BG_COLOR;
  end

  // Colour register runs every cycle
  always_ff @(posedge d) begin
    map_color <= color_next;
  end

  // Sync follows the colour by the same single stage
  always_ff @(posedge d) begin
    if (!rst_n) begin
      map_sync <= video_pkg::SYNC_IDLE;
    end else begin
      map_sync <= sync;
    end
  end

endmodule

// File: verilog/scan_decode.sv
// Free-running 800 x 525 raster; pos, tile and sync all describe the same pixel.
// Counters restart at 0,0 on reset.
`timescale 1ns/1ps
`include "maze_cfg.svh"

module scan_decode (
  input  logic                    d,
  input  logic                    rst_n,
  output video_pkg::raster_pos_t  pos,
  output maze_pkg::tile_t         tile,
  output video_pkg::sync_t        sync
);

  localparam logic [9:0] H_LAST   = 10'(`MAZE_H_TOTAL - 1);
  localparam logic [9:0] V_LAST   = 10'(`MAZE_V_TOTAL - 1);
  localparam logic [9:0] H_ACTIVE = 10'(`MAZE_H_ACTIVE);
  localparam logic [9:0] V_ACTIVE = 10'(`MAZE_V_ACTIVE);
  localparam logic [9:0] HS_START = 10'(`MAZE_H_ACTIVE + `MAZE_H_FRONT);
  localparam logic [9:0] HS_END   = 10'(`MAZE_H_ACTIVE + `MAZE_H_FRONT + `MAZE_H_SYNC);
  localparam logic [9:0] VS_START = 10'(`MAZE_V_ACTIVE + `MAZE_V_FRONT);
  localparam logic [9:0] VS_END   = 10'(`MAZE_V_ACTIVE + `MAZE_V_FRONT + `MAZE_V_SYNC);

  logic [9:0]       x_next;
  logic [9:0]       y_next;
  video_pkg::sync_t sync_next;

  // -------------------------------------------------------------------------
  // Next position with wrap and line advance
  // -------------------------------------------------------------------------

  always_comb begin
    if (pos.x == H_LAST) begin
      x_next = 10'd0;
      y_next = (pos.y == V_LAST) ? 10'd0 : pos.y + 10'd1;
    end else begin
      x_next = pos.x + 10'd1;
      y_next = pos.y;
    end
  end

  // Sync is decoded from the next position so the register lines up with pos
  always_comb begin
    sync_next.hsync  = !((x_next >= HS_START) && (x_next < HS_END));
    sync_next.vsync  = !((y_next >= VS_START) && (y_next < VS_END));
    sync_next.active = (x_next < H_ACTIVE) && (y_next < V_ACTIVE);
  end

  always_ff @(posedge d) begin
    if (!rst_n) begin
      pos.x <= 10'd0;
      pos.y <= 10'd0;
      // Position 0,0 is visible with both syncs released
      sync  <= '{hsync: 1'b1, vsync: 1'b1, active: 1'b1};
    end else begin
      pos.x <= x_next;
      pos.y <= y_next;
      sync  <= sync_next;
    end
  end

  // -------------------------------------------------------------------------
  // Tile decode
  // -------------------------------------------------------------------------

  always_comb begin
    tile.col = 5'(pos.x / 10'(`MAZE_TILE_W));
    tile.row = 4'(pos.y / 10'(`MAZE_TILE_H));
  end

endmodule

// File: verilog/maze_pkg.sv
// Fixed 20 x 12 wall map; bit n of a row is tile column n.
// An open route runs along row 1 and then down column 18 to the goal.
`include "maze_cfg.svh"

package maze_pkg;

  typedef struct packed {
    logic [4:0] col;
    logic [3:0] row;
  } tile_t;

  typedef enum logic [2:0] {
    MOVE_NONE,
    MOVE_UP,
    MOVE_DOWN,
    MOVE_LEFT,
    MOVE_RIGHT
  } move_op_e;

  typedef enum logic {
    PLAY_ROAM,
    PLAY_GOAL
  } player_state_e;

  // One single-cycle pulse per direction
  typedef struct packed {
    logic up;
    logic down;
    logic left;
    logic right;
  } move_t;

  localparam tile_t START_TILE = '{col: 5'(`MAZE_START_COL), row: 4'(`MAZE_START_ROW)};
  localparam tile_t GOAL_TILE  = '{col: 5'(`MAZE_GOAL_COL), row: 4'(`MAZE_GOAL_ROW)};

  // -------------------------------------------------------------------------
  // Wall map, column 19 on the left of each literal
  // -------------------------------------------------------------------------

  localparam logic [`MAZE_MAP_COLS-1:0] MAZE_WALLS [0:`MAZE_MAP_ROWS-1] = '{
    20'b1111_1111_1111_1111_1111,
    20'b1000_0000_0000_0000_0001,
    20'b1010_1111_0111_1101_1111,
    20'b1011_0000_1000_0010_0001,
    20'b1010_1110_1011_1011_1101,
    20'b1010_0010_0010_0000_0001,
    20'b1011_1010_1110_1110_1111,
    20'b1010_0010_0000_0010_0001,
    20'b1010_1011_1111_1011_1101,
    20'b1010_1000_0000_1000_0001,
    20'b1000_0011_1110_0011_1011,
    20'b1111_1111_1111_1111_1111
  };

  // Anything off the grid reads as wall
  function automatic logic is_wall(tile_t t);
    if (t.col >= 5'(`MAZE_MAP_COLS) || t.row >= 4'(`MAZE_MAP_ROWS)) begin
      return 1'b1;
    end
    return MAZE_WALLS[t.row][t.col];
  endfunction

endpackage

// File: verilog/video_pkg.sv
// Video path types for a 10-bit raster; both sync bits are active low.
package video_pkg;

  // -------------------------------------------------------------------------
  // Raster position
  // -------------------------------------------------------------------------

  typedef struct packed {
    logic [9:0] x;
    logic [9:0] y;
  } raster_pos_t;

  // -------------------------------------------------------------------------
  // Sync and pixel
  // -------------------------------------------------------------------------

  // hsync and vsync are low during the sync pulse
  typedef struct packed {
    logic hsync;
    logic vsync;
    logic active;
  } sync_t;

  typedef struct packed {
    sync_t      sync;
    logic [7:0] color;
  } vga_pixel_t;

  // Both syncs released, outside the picture
  localparam sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, active: 1'b0};

  // Blank pixel driven while in reset
  localparam vga_pixel_t PIXEL_IDLE = '{sync: SYNC_IDLE, color: 8'h00};

endpackage

// File: verilog/maze_cfg.svh
// Raster timing is the standard 640x480 mode at one pixel per clock.
// The tile size must divide the active area evenly.
`ifndef MAZE_CFG_SVH
`define MAZE_CFG_SVH

// Horizontal timing in pixels
`define MAZE_H_ACTIVE 640
`define MAZE_H_FRONT  16
`define MAZE_H_SYNC   96
`define MAZE_H_BACK   48
`define MAZE_H_TOTAL  (`MAZE_H_ACTIVE + `MAZE_H_FRONT + `MAZE_H_SYNC + `MAZE_H_BACK)

// Vertical timing in lines
`define MAZE_V_ACTIVE 480
`define MAZE_V_FRONT  10
`define MAZE_V_SYNC   2
`define MAZE_V_BACK   33
`define MAZE_V_TOTAL  (`MAZE_V_ACTIVE + `MAZE_V_FRONT + `MAZE_V_SYNC + `MAZE_V_BACK)

// Tile geometry, giving a 20 x 12 map
`define MAZE_TILE_W   32
`define MAZE_TILE_H   40
`define MAZE_MAP_COLS 20
`define MAZE_MAP_ROWS 12

// 8-bit RGB332 colours
`define MAZE_BG_COLOR     8'hB6
`define MAZE_PLAYER_COLOR 8'hE0

`define MAZE_START_COL 1
`define MAZE_START_ROW 1
`define MAZE_GOAL_COL  18
`define MAZE_GOAL_ROW  10

`endif
